// File: cpu_defs_pkg.sv
package cpu_defs_pkg;

	localparam int ISSUE_NUM = 2;
	localparam int REG_NUM   = 32;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		uint32_t   wdata;
	} exec_result_t;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// funct field of SPECIAL
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

// File: decode_and_issue.sv
`timescale 1ns/1ps

module decode_and_issue import cpu_defs_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic         [ISSUE_NUM-1:0] fetch_valid,
	input  uint32_t      [ISSUE_NUM-1:0] fetch_instr,
	output logic         [1:0]           fetch_ack,
	output reg_addr_t    [3:0]           reg_raddr,
	input  uint32_t      [3:0]           reg_rdata,
	input  exec_result_t [ISSUE_NUM-1:0] ex_fwd,
	input  exec_result_t [ISSUE_NUM-1:0] wb_fwd,
	issue_if.issue                       lane [ISSUE_NUM-1:0]
);

	typedef struct packed {
		alu_op_t   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		logic      use_imm;
		uint32_t   imm;
	} decoded_t;

	// unknown words fall through as r0 = 0 + 0
	function automatic decoded_t decode(input uint32_t instr);
		decoded_t d;
		d = '0;
		case (instr[31:26])
			OP_SPECIAL: begin
				d.rd = instr[15:11];
				d.ra = instr[25:21];
				d.rb = instr[20:16];
				case (instr[5:0])
					FN_ADDU: d.op = ALU_ADD;
					FN_SUBU: d.op = ALU_SUB;
					FN_AND:  d.op = ALU_AND;
					FN_OR:   d.op = ALU_OR;
					FN_XOR:  d.op = ALU_XOR;
					FN_NOR:  d.op = ALU_NOR;
					FN_SLT:  d.op = ALU_SLT;
					FN_SLTU: d.op = ALU_SLTU;
					FN_SLL, FN_SRL: begin
						d.op = (instr[5:0] == FN_SLL) ? ALU_SLL : ALU_SRL;
						// shifts take rt as the source and shamt as opb
						d.ra = instr[20:16];
						d.rb = '0;
						d.use_imm = 1'b1;
						d.imm = {27'b0, instr[10:6]};
					end
					default: d = '0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				d.rd = instr[20:16];
				d.ra = (instr[31:26] == OP_LUI) ? 5'd0 : instr[25:21];
				d.use_imm = 1'b1;
				d.imm = {16'b0, instr[15:0]};
				case (instr[31:26])
					OP_ADDIU: d.op = ALU_ADD;
					OP_SLTI:  d.op = ALU_SLT;
					OP_ANDI:  d.op = ALU_AND;
					OP_ORI:   d.op = ALU_OR;
					OP_XORI:  d.op = ALU_XOR;
					default:  d.op = ALU_LUI;
				endcase
				if (instr[31:26] == OP_ADDIU || instr[31:26] == OP_SLTI) begin
					d.imm = {{16{instr[15]}}, instr[15:0]};
				end
			end
			default: d = '0;
		endcase
		return d;
	endfunction

	// youngest producer wins in the order EX1, EX0, WB1, WB0, register file
	function automatic uint32_t forward(
		input reg_addr_t                      addr,
		input uint32_t                        rf_data,
		input exec_result_t [ISSUE_NUM-1:0]   ex,
		input exec_result_t [ISSUE_NUM-1:0]   wb
	);
		uint32_t v;
		v = rf_data;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (wb[i].valid && wb[i].rd != '0 && wb[i].rd == addr) begin
				v = wb[i].wdata;
			end
		end
		for (int i = 0; i < ISSUE_NUM; i++) begin
			if (ex[i].valid && ex[i].rd != '0 && ex[i].rd == addr) begin
				v = ex[i].wdata;
			end
		end
		return v;
	endfunction

	decoded_t [ISSUE_NUM-1:0] dec;
	uint32_t  [ISSUE_NUM-1:0] opa_sel;
	uint32_t  [ISSUE_NUM-1:0] opb_sel;
	logic                     pair_dep;
	logic     [ISSUE_NUM-1:0] accept;

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			dec[i] = decode(fetch_instr[i]);
			reg_raddr[2*i] = dec[i].ra;
			reg_raddr[2*i+1] = dec[i].rb;
			opa_sel[i] = forward(dec[i].ra, reg_rdata[2*i], ex_fwd, wb_fwd);
			opb_sel[i] = forward(dec[i].rb, reg_rdata[2*i+1], ex_fwd, wb_fwd);
			if (dec[i].use_imm) begin
				opb_sel[i] = dec[i].imm;
			end
		end
	end

	// slot 1 reading slot 0's destination must wait a cycle
	assign pair_dep = dec[0].rd != '0 &&
		(dec[1].ra == dec[0].rd || (!dec[1].use_imm && dec[1].rb == dec[0].rd));

	always_comb begin
		if (!fetch_valid[0]) begin
			fetch_ack = 2'd0;
		end else if (!fetch_valid[1] || pair_dep) begin
			fetch_ack = 2'd1;
		end else begin
			fetch_ack = 2'd2;
		end
	end

	assign accept[0] = fetch_ack != 2'd0;
	assign accept[1] = fetch_ack == 2'd2;

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_issue
		always_ff @(posedge clk) begin
			if (rst) begin
				lane[i].valid <= 1'b0;
			end else begin
				lane[i].valid <= accept[i];
			end
		end

		always_ff @(posedge clk) begin
			lane[i].op  <= dec[i].op;
			lane[i].rd  <= dec[i].rd;
			lane[i].opa <= opa_sel[i];
			lane[i].opb <= opb_sel[i];
		end
	end

endmodule

// File: instr_exec.sv
`timescale 1ns/1ps

module instr_exec import cpu_defs_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	issue_if.exec        lane,
	output exec_result_t ex_out,
	output exec_result_t result
);

	uint32_t    alu_out;
	logic [4:0] sa;

	// shifts only look at the low five bits
	assign sa = lane.opb[4:0];

	always_comb begin
		case (lane.op)
			ALU_ADD:  alu_out = lane.opa + lane.opb;
			ALU_SUB:  alu_out = lane.opa - lane.opb;
			ALU_AND:  alu_out = lane.opa & lane.opb;
			ALU_OR:   alu_out = lane.opa | lane.opb;
			ALU_XOR:  alu_out = lane.opa ^ lane.opb;
			ALU_NOR:  alu_out = ~(lane.opa | lane.opb);
			ALU_SLT:  alu_out = {31'b0, $signed(lane.opa) < $signed(lane.opb)};
			ALU_SLTU: alu_out = {31'b0, lane.opa < lane.opb};
			ALU_SLL:  alu_out = lane.opa << sa;
			ALU_SRL:  alu_out = lane.opa >> sa;
			ALU_LUI:  alu_out = {lane.opb[15:0], 16'b0};
			default:  alu_out = '0;
		endcase
	end

	// visible to decode in the same cycle for EX forwarding
	always_comb begin
		ex_out.valid = lane.valid;
		ex_out.rd    = lane.rd;
		ex_out.wdata = alu_out;
	end

	// EX/WB stage register
	always_ff @(posedge clk) begin
		if (rst) begin
			result.valid <= 1'b0;
		end else begin
			result <= ex_out;
		end
	end

endmodule

// File: issue_if.sv
`timescale 1ns/1ps

interface issue_if import cpu_defs_pkg::*; ();

	logic      valid;
	alu_op_t   op;
	reg_addr_t rd;
	uint32_t   opa;
	uint32_t   opb;

	// decode side owns the ID/EX registers
	modport issue (
		output valid, op, rd, opa, opb
	);

	modport exec (
		input valid, op, rd, opa, opb
	);

endinterface

// File: mini_core.f
cpu_defs_pkg.sv
issue_if.sv
regfile.sv
decode_and_issue.sv
instr_exec.sv
writeback.sv
mini_core.sv
tb_clock_gen.sv
mini_core_tb.sv

// File: mini_core.sv
`timescale 1ns/1ps

module mini_core import cpu_defs_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [ISSUE_NUM-1:0]       fetch_valid,
	input  logic [ISSUE_NUM-1:0][31:0] fetch_instr,
	output logic [1:0]                 fetch_ack,
	output logic [ISSUE_NUM-1:0]       commit_valid,
	output logic [ISSUE_NUM-1:0][4:0]  commit_rd,
	output logic [ISSUE_NUM-1:0][31:0] commit_wdata
);

	// register file ports
	reg_addr_t [3:0]           reg_raddr;
	uint32_t   [3:0]           reg_rdata;
	logic      [ISSUE_NUM-1:0] reg_we;
	reg_addr_t [ISSUE_NUM-1:0] reg_waddr;
	uint32_t   [ISSUE_NUM-1:0] reg_wdata;

	exec_result_t [ISSUE_NUM-1:0] ex_out;
	exec_result_t [ISSUE_NUM-1:0] exec_result;

	issue_if lane [ISSUE_NUM-1:0] ();

	regfile regfile_inst (
		.clk,
		.rst,
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata ),
		.we    ( reg_we    ),
		.waddr ( reg_waddr ),
		.wdata ( reg_wdata )
	);

	decode_and_issue decode_issue_inst (
		.clk,
		.rst,
		.fetch_valid,
		.fetch_instr,
		.fetch_ack,
		.reg_raddr,
		.reg_rdata,
		.ex_fwd ( ex_out      ),
		.wb_fwd ( exec_result ),
		.lane   ( lane        )
	);

	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_exec
		instr_exec exec_inst (
			.clk,
			.rst,
			.lane   ( lane[i]        ),
			.ex_out ( ex_out[i]      ),
			.result ( exec_result[i] )
		);
	end

	writeback writeback_inst (
		.result ( exec_result ),
		.reg_we,
		.reg_waddr,
		.reg_wdata,
		.commit_valid,
		.commit_rd,
		.commit_wdata
	);

endmodule

// File: mini_core_tb.sv
`timescale 1ns/1ps

module mini_core_tb import cpu_defs_pkg::*; ();

	logic             clk;
	logic             rst;
	logic [1:0]       fetch_valid = '0;
	logic [1:0][31:0] fetch_instr = '0;
	logic [1:0]       fetch_ack;
	logic [1:0]       commit_valid;
	logic [1:0][4:0]  commit_rd;
	logic [1:0][31:0] commit_wdata;

	logic [31:0] prog_q[$];
	string       prog_name_q[$];
	logic [4:0]  exp_rd_q[$];
	logic [31:0] exp_val_q[$];
	string       exp_name_q[$];
	int          exp_cyc_q[$];
	logic [31:0] model_regs [32];
	logic [31:0] lfsr_state;
	int          errors;
	int          commits;
	int          cycles;
	int          limit;
	logic        done;
	logic        timed_out;

	tb_clock_gen clock_gen (
		.clk,
		.rst
	);

	mini_core i_mini_core (
		.clk,
		.rst,
		.fetch_valid,
		.fetch_instr,
		.fetch_ack,
		.commit_valid,
		.commit_rd,
		.commit_wdata
	);

	// one output bit per step
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return v;
	endfunction

	function automatic logic [31:0] encode_reg(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] encode_imm(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic special_known(input logic [5:0] fn);
		return fn inside {FN_SLL, FN_SRL, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
			FN_NOR, FN_SLT, FN_SLTU};
	endfunction

	function automatic logic imm_known(input logic [5:0] op);
		return op inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	endfunction

	// unknown words retire into r0
	function automatic logic [4:0] dest_reg(input logic [31:0] w);
		logic [4:0] d;
		d = 5'd0;
		if (w[31:26] == OP_SPECIAL && special_known(w[5:0])) begin
			d = w[15:11];
		end else if (imm_known(w[31:26])) begin
			d = w[20:16];
		end
		return d;
	endfunction

	function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
		logic hit;
		hit = 1'b0;
		if (r != 5'd0) begin
			if (w[31:26] == OP_SPECIAL && special_known(w[5:0])) begin
				if (w[5:0] == FN_SLL || w[5:0] == FN_SRL) begin
					hit = w[20:16] == r;
				end else begin
					hit = w[25:21] == r || w[20:16] == r;
				end
			end else if (imm_known(w[31:26]) && w[31:26] != OP_LUI) begin
				hit = w[25:21] == r;
			end
		end
		return hit;
	endfunction

	// architectural result from the model registers
	function automatic logic [31:0] ref_exec(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] v;
		a = model_regs[w[25:21]];
		b = model_regs[w[20:16]];
		simm = {{16{w[15]}}, w[15:0]};
		zimm = {16'b0, w[15:0]};
		v = '0;
		case (w[31:26])
			OP_SPECIAL: begin
				case (w[5:0])
					FN_SLL:  v = b << w[10:6];
					FN_SRL:  v = b >> w[10:6];
					FN_ADDU: v = a + b;
					FN_SUBU: v = a - b;
					FN_AND:  v = a & b;
					FN_OR:   v = a | b;
					FN_XOR:  v = a ^ b;
					FN_NOR:  v = ~(a | b);
					FN_SLT:  v = {31'b0, $signed(a) < $signed(b)};
					FN_SLTU: v = {31'b0, a < b};
					default: v = '0;
				endcase
			end
			OP_ADDIU: v = a + simm;
			OP_SLTI:  v = {31'b0, $signed(a) < $signed(simm)};
			OP_ANDI:  v = a & zimm;
			OP_ORI:   v = a | zimm;
			OP_XORI:  v = a ^ zimm;
			OP_LUI:   v = {w[15:0], 16'b0};
			default:  v = '0;
		endcase
		return v;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [3:0]  k;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  sa;
		logic [15:0] imm;
		logic [31:0] w;
		k = 4'(rand_bits(4));
		rd = 5'(rand_bits(5));
		rs = 5'(rand_bits(5));
		rt = 5'(rand_bits(5));
		sa = 5'(rand_bits(5));
		imm = 16'(rand_bits(16));
		case (k)
			4'd0:    w = encode_reg(FN_ADDU, rd, rs, rt, 5'd0);
			4'd1:    w = encode_reg(FN_SUBU, rd, rs, rt, 5'd0);
			4'd2:    w = encode_reg(FN_AND, rd, rs, rt, 5'd0);
			4'd3:    w = encode_reg(FN_OR, rd, rs, rt, 5'd0);
			4'd4:    w = encode_reg(FN_XOR, rd, rs, rt, 5'd0);
			4'd5:    w = encode_reg(FN_NOR, rd, rs, rt, 5'd0);
			4'd6:    w = encode_reg(FN_SLT, rd, rs, rt, 5'd0);
			4'd7:    w = encode_reg(FN_SLTU, rd, rs, rt, 5'd0);
			4'd8:    w = encode_reg(FN_SLL, rd, 5'd0, rt, sa);
			4'd9:    w = encode_reg(FN_SRL, rd, 5'd0, rt, sa);
			4'd10:   w = encode_imm(OP_ADDIU, rt, rs, imm);
			4'd11:   w = encode_imm(OP_SLTI, rt, rs, imm);
			4'd12:   w = encode_imm(OP_ANDI, rt, rs, imm);
			4'd13:   w = encode_imm(OP_ORI, rt, rs, imm);
			4'd14:   w = encode_imm(OP_XORI, rt, rs, imm);
			default: w = encode_imm(OP_LUI, rt, 5'd0, imm);
		endcase
		return w;
	endfunction

	task automatic add_instr(input logic [31:0] w, input string name);
		prog_q.push_back(w);
		prog_name_q.push_back(name);
	endtask

	task automatic build_program();
		logic [4:0] p0;
		logic [4:0] p1;
		logic [4:0] q0;
		logic [4:0] q1;
		logic [4:0] n0;
		logic [4:0] n1;
		for (int r = 1; r < 16; r++) begin
			add_instr(encode_imm(OP_LUI, 5'(r), 5'd0, 16'(rand_bits(16))), "load");
			add_instr(encode_imm(OP_ORI, 5'(r), 5'(r), 16'(rand_bits(16))), "load");
		end
		// negative against positive and both shift directions
		add_instr(encode_imm(OP_LUI, 5'd24, 5'd0, 16'h8000), "compare");
		add_instr(encode_imm(OP_ADDIU, 5'd25, 5'd0, 16'h0001), "compare");
		add_instr(encode_reg(FN_SLT, 5'd26, 5'd24, 5'd25, 5'd0), "compare");
		add_instr(encode_reg(FN_SLTU, 5'd27, 5'd24, 5'd25, 5'd0), "compare");
		add_instr(encode_imm(OP_SLTI, 5'd28, 5'd24, 16'hffff), "compare");
		add_instr(encode_reg(FN_SRL, 5'd29, 5'd0, 5'd24, 5'd31), "compare");
		add_instr(encode_reg(FN_SLL, 5'd30, 5'd0, 5'd25, 5'd31), "compare");
		for (int i = 0; i < 40; i++) begin
			add_instr(random_instr(), "random_ops");
		end
		for (int i = 0; i < 6; i++) begin
			add_instr(encode_imm(OP_ADDIU, 5'(16 + i), 5'(i + 1), 16'(rand_bits(16))),
				"independent_pairs");
			add_instr(encode_reg(FN_XOR, 5'(24 + i), 5'(i + 2), 5'(i + 3), 5'd0),
				"independent_pairs");
		end
		// every neighbour depends on the one before it
		add_instr(encode_imm(OP_ADDIU, 5'd5, 5'd0, 16'h1234), "pair_dependence");
		add_instr(encode_reg(FN_ADDU, 5'd6, 5'd5, 5'd5, 5'd0), "pair_dependence");
		add_instr(encode_reg(FN_SUBU, 5'd7, 5'd6, 5'd5, 5'd0), "pair_dependence");
		add_instr(encode_reg(FN_XOR, 5'd8, 5'd7, 5'd6, 5'd0), "pair_dependence");
		p0 = 5'd1;
		p1 = 5'd2;
		q0 = 5'd3;
		q1 = 5'd4;
		for (int j = 0; j < 8; j++) begin
			n0 = 5'(17 + 2 * (j % 4));
			n1 = n0 + 5'd1;
			add_instr(encode_reg(FN_ADDU, n0, p0, q1, 5'd0), "forwarding");
			add_instr(encode_reg(FN_SUBU, n1, p1, q0, 5'd0), "forwarding");
			q0 = p0;
			q1 = p1;
			p0 = n0;
			p1 = n1;
		end
		// the second word depends on the first so the next two always pair up
		add_instr(encode_imm(OP_ADDIU, 5'd20, 5'd0, 16'd5), "same_rd");
		add_instr(encode_imm(OP_ADDIU, 5'd20, 5'd20, 16'd111), "same_rd");
		add_instr(encode_imm(OP_ADDIU, 5'd20, 5'd0, 16'd222), "same_rd");
		add_instr(encode_reg(FN_ADDU, 5'd21, 5'd20, 5'd0, 5'd0), "same_rd");
		add_instr(encode_imm(OP_ADDIU, 5'd0, 5'd0, 16'd5), "reg_zero");
		add_instr(32'hffffffff, "reg_zero");
		add_instr(32'h0000003f, "reg_zero");
		add_instr(encode_reg(FN_ADDU, 5'd22, 5'd0, 5'd0, 5'd0), "reg_zero");
		add_instr(encode_imm(OP_ORI, 5'd23, 5'd0, 16'd0), "reg_zero");
		// r20 is out of forwarding range by now and comes from the register file
		add_instr(encode_reg(FN_OR, 5'd19, 5'd20, 5'd0, 5'd0), "same_rd");
	endtask

	task automatic check_commits();
		logic [4:0]  e_rd;
		logic [31:0] e_val;
		string       e_name;
		int          e_cyc;
		for (int s = 0; s < 2; s++) begin
			if (commit_valid[s]) begin
				if (exp_rd_q.size() == 0) begin
					errors++;
					$display("Commit on slot %0d with no instruction outstanding", s);
				end else begin
					e_rd = exp_rd_q.pop_front();
					e_val = exp_val_q.pop_front();
					e_name = exp_name_q.pop_front();
					e_cyc = exp_cyc_q.pop_front();
					commits++;
					assert (commit_rd[s] == e_rd && commit_wdata[s] == e_val) else begin
						errors++;
						$display("Mismatch in %s slot %0d: expected r%0d = %h, actual r%0d = %h",
							e_name, s, e_rd, e_val, commit_rd[s], commit_wdata[s]);
					end
					assert (cycles == e_cyc + 2) else begin
						errors++;
						$display("Mismatch in %s slot %0d latency: expected %0d, actual %0d",
							e_name, s, 2, cycles - e_cyc);
					end
				end
			end
		end
	endtask

	task automatic check_ack();
		logic [1:0] exp_ack;
		string      name;
		name = (prog_name_q.size() > 0) ? prog_name_q[0] : "idle";
		if (!fetch_valid[0]) begin
			exp_ack = 2'd0;
		end else if (!fetch_valid[1] || reads_reg(fetch_instr[1], dest_reg(fetch_instr[0]))) begin
			exp_ack = 2'd1;
		end else begin
			exp_ack = 2'd2;
		end
		assert (fetch_ack == exp_ack) else begin
			errors++;
			$display("Mismatch in %s fetch_ack: expected %0d, actual %0d",
				name, exp_ack, fetch_ack);
		end
	endtask

	// the model retires words in order as they are acknowledged
	task automatic consume();
		logic [31:0] w;
		logic [4:0]  d;
		logic [31:0] v;
		for (int i = 0; i < int'(fetch_ack); i++) begin
			if (prog_q.size() == 0) begin
				errors++;
				$display("fetch_ack took a word that was never presented");
				break;
			end
			w = prog_q.pop_front();
			exp_name_q.push_back(prog_name_q.pop_front());
			d = dest_reg(w);
			v = ref_exec(w);
			exp_rd_q.push_back(d);
			exp_val_q.push_back(v);
			exp_cyc_q.push_back(cycles);
			if (d != 5'd0) begin
				model_regs[d] = v;
			end
		end
	endtask

	task automatic present_window();
		fetch_valid <= {prog_q.size() >= 2, prog_q.size() >= 1};
		fetch_instr[0] <= (prog_q.size() >= 1) ? prog_q[0] : '0;
		fetch_instr[1] <= (prog_q.size() >= 2) ? prog_q[1] : '0;
	endtask

	task automatic end_run();
		$display("commits checked: %0d, errors: %0d", commits, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		lfsr_state = 32'd13;
		errors = 0;
		commits = 0;
		cycles = 0;
		done = 1'b0;
		timed_out = 1'b0;
		build_program();
		limit = 2 * prog_q.size() + 50;
		while (!done && !timed_out) begin
			@(posedge clk);
			if (rst) begin
				for (int r = 0; r < 32; r++) begin
					model_regs[r] = '0;
				end
				fetch_valid <= '0;
				fetch_instr <= '0;
			end else begin
				cycles++;
				check_commits();
				check_ack();
				consume();
				present_window();
				done = prog_q.size() == 0 && exp_rd_q.size() == 0;
				timed_out = cycles >= limit;
			end
		end
		if (!done) begin
			errors++;
			$display("Timeout: the program did not retire within %0d cycles", limit);
		end
		end_run();
	end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile import cpu_defs_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  reg_addr_t [3:0]           raddr,
	output uint32_t   [3:0]           rdata,
	input  logic      [ISSUE_NUM-1:0] we,
	input  reg_addr_t [ISSUE_NUM-1:0] waddr,
	input  uint32_t   [ISSUE_NUM-1:0] wdata
);

	uint32_t regs [REG_NUM];

	// port 1 comes last so it wins on equal addresses
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < ISSUE_NUM; i++) begin
				if (we[i]) begin
					regs[waddr[i]] <= wdata[i];
				end
			end
		end
	end

	// r0 is hardwired zero
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (raddr[i] == '0) begin
				rdata[i] = '0;
			end else begin
				rdata[i] = regs[raddr[i]];
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the mini_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mini_core_tb \
	-f mini_core.f -o mini_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/mini_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// held over the first two rising edges
	initial begin
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: writeback.sv
`timescale 1ns/1ps

module writeback import cpu_defs_pkg::*; (
	input  exec_result_t [ISSUE_NUM-1:0] result,
	output logic         [ISSUE_NUM-1:0] reg_we,
	output reg_addr_t    [ISSUE_NUM-1:0] reg_waddr,
	output uint32_t      [ISSUE_NUM-1:0] reg_wdata,
	output logic         [ISSUE_NUM-1:0] commit_valid,
	output reg_addr_t    [ISSUE_NUM-1:0] commit_rd,
	output uint32_t      [ISSUE_NUM-1:0] commit_wdata
);

	logic same_rd;

	// both lanes target one register and slot 1 is younger
	assign same_rd = result[1].valid && result[1].rd == result[0].rd;

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			reg_we[i]       = result[i].valid && result[i].rd != '0;
			reg_waddr[i]    = result[i].rd;
			reg_wdata[i]    = result[i].wdata;
			commit_valid[i] = result[i].valid;
			commit_rd[i]    = result[i].rd;
			commit_wdata[i] = result[i].wdata;
		end
		if (same_rd) begin
			reg_we[0] = 1'b0;
		end
	end

endmodule
